// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int INST_W = 32;

    // --------------------------------------------------
    // Instruction field positions
    // --------------------------------------------------
    localparam int OPC_W   = 7;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_ALT  = 30;  // Selects SUB and SRA.

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    localparam logic [OPC_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPC_W-1:0] OP_REG    = 7'b0110011;

    // ALU funct3.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Signed branch funct3 only.
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

endpackage

// File: hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN    = 32;
    localparam int REG_CNT = 32;
    localparam int REG_AW  = 5;
    localparam int IMEM_AW = 30;
    localparam int SHAMT_W = $clog2(XLEN);

    localparam logic [XLEN-1:0] PC_STEP = 4;  // Bytes per instruction.

    typedef enum logic [2:0] {
        CL_LUI,
        CL_AUIPC,
        CL_JAL,
        CL_JALR,
        CL_BRANCH,
        CL_IMM,
        CL_REG,
        CL_ILLEGAL
    } op_class_e;

    typedef struct packed {
        op_class_e         op_class;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [2:0]        funct3;
        logic              alt;
        logic [XLEN-1:0]   imm;
        logic              wr_en;
    } decoded_t;

    // One record per finished instruction.
    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              wr_en;
        logic [XLEN-1:0]   value;
        logic [XLEN-1:0]   next_pc;
    } retire_t;

endpackage

// File: hdl/decoder.sv
module decoder import rv_isa_pkg::*, core_pkg::*; (
    input  logic [INST_W-1:0] inst,
    output decoded_t          dec
);

    logic [OPC_W-1:0] opcode;
    logic [2:0]       funct3;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_u;
    logic [XLEN-1:0]  imm_j;
    logic [XLEN-1:0]  imm_b;
    logic             sign;

    assign opcode = inst[OPC_W-1:0];
    assign funct3 = inst[F3_LSB +: 3];
    assign sign   = inst[INST_W-1];

    // Sign-extended immediates.
    assign imm_i = {{(XLEN-12){sign}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{(XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{(XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec.rd     = inst[RD_LSB +: REG_AW];
        dec.rs1    = inst[RS1_LSB +: REG_AW];
        dec.rs2    = inst[RS2_LSB +: REG_AW];
        dec.funct3 = funct3;
        dec.alt    = 1'b0;
        dec.imm    = imm_i;
        dec.wr_en  = 1'b0;
        case (opcode)
            OP_LUI: begin
                dec.op_class = CL_LUI;
                dec.imm      = imm_u;
                dec.wr_en    = 1'b1;
            end
            OP_AUIPC: begin
                dec.op_class = CL_AUIPC;
                dec.imm      = imm_u;
                dec.wr_en    = 1'b1;
            end
            OP_JAL: begin
                dec.op_class = CL_JAL;
                dec.imm      = imm_j;
                dec.wr_en    = 1'b1;
            end
            OP_JALR: begin
                dec.op_class = CL_JALR;
                dec.wr_en    = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm = imm_b;
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE}) begin
                    dec.op_class = CL_BRANCH;
                end else begin
                    dec.op_class = CL_ILLEGAL;
                end
            end
            OP_IMM: begin
                dec.op_class = CL_IMM;
                dec.alt      = inst[F7_ALT] && (funct3 == F3_SR);  // Only SRAI.
                dec.wr_en    = 1'b1;
            end
            OP_REG: begin
                dec.op_class = CL_REG;
                dec.alt      = inst[F7_ALT];
                dec.wr_en    = 1'b1;
            end
            default: dec.op_class = CL_ILLEGAL;
        endcase
    end

    always_comb begin
        assert (!(dec.op_class == CL_ILLEGAL && dec.wr_en))
            else $error("illegal instruction decoded with register write");
    end

endmodule

// File: hdl/reg_file.sv
module reg_file import core_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    output logic [XLEN-1:0]   rd1,
    output logic [XLEN-1:0]   rd2,
    input  logic              we,
    input  logic [REG_AW-1:0] wa,
    input  logic [XLEN-1:0]   wd
);

    logic [XLEN-1:0] regs [REG_CNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero.
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/alu.sv
module alu import rv_isa_pkg::*, core_pkg::*; (
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] value
);

    logic [XLEN-1:0]    op2;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    arith;

    assign op2   = (dec.op_class == CL_REG) ? b : dec.imm;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (dec.funct3)
            F3_ADD:  arith = dec.alt ? a - op2 : a + op2;
            F3_SLL:  arith = a << shamt;
            F3_SLT:  arith = {{(XLEN-1){1'b0}}, $signed(a) < $signed(op2)};
            F3_SLTU: arith = {{(XLEN-1){1'b0}}, a < op2};
            F3_XOR:  arith = a ^ op2;
            F3_SR: begin
                if (dec.alt) begin
                    arith = $signed(a) >>> shamt;  // Arithmetic shift.
                end else begin
                    arith = a >> shamt;
                end
            end
            F3_OR:   arith = a | op2;
            default: arith = a & op2;
        endcase
    end

    // Destination value per class.
    always_comb begin
        case (dec.op_class)
            CL_LUI:          value = dec.imm;
            CL_AUIPC:        value = pc + dec.imm;
            CL_JAL, CL_JALR: value = pc + PC_STEP;  // Link.
            CL_IMM, CL_REG:  value = arith;
            default:         value = '0;
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
module branch_unit import rv_isa_pkg::*, core_pkg::*; (
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] next_pc
);

    logic            taken;
    logic [XLEN-1:0] jalr_sum;

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  taken = (a == b);
            F3_BNE:  taken = (a != b);
            F3_BLT:  taken = $signed(a) < $signed(b);
            F3_BGE:  taken = $signed(a) >= $signed(b);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = a + dec.imm;

    always_comb begin
        case (dec.op_class)
            CL_JAL:    next_pc = pc + dec.imm;
            CL_JALR:   next_pc = {jalr_sum[XLEN-1:1], 1'b0};
            CL_BRANCH: next_pc = taken ? pc + dec.imm : pc + PC_STEP;
            default:   next_pc = pc + PC_STEP;
        endcase
    end

    always_comb begin
        assert (next_pc[1:0] == 2'b00)
            else $error("misaligned next pc %h", next_pc);
    end

endmodule

// File: hdl/core_top.sv
module core_top import rv_isa_pkg::*, core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic               imem_req,
    output logic [IMEM_AW-1:0] imem_addr,
    input  logic [INST_W-1:0]  imem_data,
    output retire_t            retire
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LATCH,
        ST_EXEC,
        ST_RETIRE
    } state_e;

    state_e          state;
    logic [XLEN-1:0] pc;
    logic [INST_W-1:0] inst_q;

    decoded_t        dec;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;

    // Execute register.
    decoded_t        ex_dec;
    logic [XLEN-1:0] ex_a;
    logic [XLEN-1:0] ex_b;

    logic [XLEN-1:0] alu_value;
    logic [XLEN-1:0] br_next_pc;
    logic            wb_en;
    logic            rf_we;

    // --------------------------------------------------
    // Stage sequencer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  state <= ST_FETCH;
                ST_FETCH: state <= ST_LATCH;
                ST_LATCH: state <= ST_EXEC;
                ST_EXEC:  state <= ST_RETIRE;
                default:  state <= ST_FETCH;
            endcase
        end
    end

    assign imem_req  = (state == ST_FETCH);
    assign imem_addr = pc[IMEM_AW+1:2];  // Word address.

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (state == ST_RETIRE) begin
            pc <= br_next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LATCH) begin
            inst_q <= imem_data;  // Read data arrives one cycle after req.
        end
        if (state == ST_EXEC) begin
            ex_dec <= dec;
            ex_a   <= rd1;
            ex_b   <= rd2;
        end
    end

    // --------------------------------------------------
    // Decode, operands and execute
    // --------------------------------------------------
    decoder decoder_i (
        .inst (inst_q),
        .dec  (dec)
    );

    assign wb_en = ex_dec.wr_en && (ex_dec.rd != '0);
    assign rf_we = (state == ST_RETIRE) && wb_en;

    reg_file reg_file_i (
        .clk (clk),
        .rst (rst),
        .rs1 (dec.rs1),
        .rs2 (dec.rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (rf_we),
        .wa  (ex_dec.rd),
        .wd  (alu_value)
    );

    alu alu_i (
        .dec   (ex_dec),
        .pc    (pc),
        .a     (ex_a),
        .b     (ex_b),
        .value (alu_value)
    );

    branch_unit branch_unit_i (
        .dec     (ex_dec),
        .pc      (pc),
        .a       (ex_a),
        .b       (ex_b),
        .next_pc (br_next_pc)
    );

    // --------------------------------------------------
    // Retire record
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= '0;
        end else begin
            retire.valid <= (state == ST_RETIRE);  // One-cycle pulse.
            if (state == ST_RETIRE) begin
                retire.illegal <= (ex_dec.op_class == CL_ILLEGAL);
                retire.pc      <= pc;
                retire.rd      <= ex_dec.rd;
                retire.wr_en   <= wb_en;
                retire.value   <= alu_value;
                retire.next_pc <= br_next_pc;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) retire.valid |=> !retire.valid)
        else $error("retire valid high in two consecutive cycles");

endmodule

// File: sim/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural state of the reference model.
logic [31:0] ref_regs [32] = '{default: '0};
logic [31:0] ref_pc = '0;

// Executes one instruction at ref_pc, updates the state, returns the retire fields.
function automatic retire_t ref_step(input logic [31:0] inst);
    retire_t     r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] op2;
    logic        writes;
    logic        taken;
    opc   = inst[6:0];
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = ref_regs[inst[19:15]];
    b     = ref_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    op2   = (opc == OP_REG) ? b : imm_i;
    sh    = op2[4:0];
    r         = '0;
    r.valid   = 1'b1;
    r.pc      = ref_pc;
    r.rd      = rd;
    r.next_pc = ref_pc + 32'd4;
    writes    = 1'b1;
    case (opc)
        OP_LUI:   r.value = {inst[31:12], 12'h000};
        OP_AUIPC: r.value = ref_pc + {inst[31:12], 12'h000};
        OP_JAL: begin
            r.value   = ref_pc + 32'd4;
            r.next_pc = ref_pc + imm_j;
        end
        OP_JALR: begin
            r.value   = ref_pc + 32'd4;
            r.next_pc = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            writes = 1'b0;
            taken  = 1'b0;
            case (f3)
                F3_BEQ:  taken = (a == b);
                F3_BNE:  taken = (a != b);
                F3_BLT:  taken = ($signed(a) < $signed(b));
                F3_BGE:  taken = ($signed(a) >= $signed(b));
                default: r.illegal = 1'b1;
            endcase
            if (taken) begin
                r.next_pc = ref_pc + imm_b;
            end
        end
        OP_IMM, OP_REG: begin
            case (f3)
                F3_ADD: begin
                    if (opc == OP_REG && inst[30]) begin
                        r.value = a - op2;  // SUB.
                    end else begin
                        r.value = a + op2;
                    end
                end
                F3_SLL:  r.value = a << sh;
                F3_SLT:  r.value = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
                F3_SLTU: r.value = (a < op2) ? 32'd1 : 32'd0;
                F3_XOR:  r.value = a ^ op2;
                F3_SR: begin
                    if (inst[30]) begin
                        r.value = $signed(a) >>> sh;
                    end else begin
                        r.value = a >> sh;
                    end
                end
                F3_OR:   r.value = a | op2;
                default: r.value = a & op2;
            endcase
        end
        default: begin
            writes    = 1'b0;
            r.illegal = 1'b1;
        end
    endcase
    r.wr_en = writes && (rd != 5'd0);
    if (r.wr_en) begin
        ref_regs[rd] = r.value;
    end
    ref_pc = r.next_pc;
    return r;
endfunction

`endif

// File: sim/core_tb.sv
module core_tb import rv_isa_pkg::*, core_pkg::*; ();

    localparam int N_INSTR = 400;
    localparam int RST_CYC = 16;
    localparam int TIMEOUT = N_INSTR * 4 + RST_CYC + 50;
    localparam int ROM_W   = 64;
    localparam int NT      = 6;
    localparam int T_RESET = 0;
    localparam int T_SEQ   = 1;
    localparam int T_ALU   = 2;
    localparam int T_UPPER = 3;
    localparam int T_CTRL  = 4;
    localparam int T_ILL   = 5;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               imem_req;
    logic [IMEM_AW-1:0] imem_addr;
    logic [INST_W-1:0]  imem_data = '0;
    retire_t            retire;
    logic               req_q = 1'b0;
    logic [IMEM_AW-1:0] addr_q = '0;

    logic [31:0] rom [ROM_W];
    logic [31:0] lcg_state = 32'h823f_7c11;
    int          cycle_cnt = 0;
    int          retire_cnt = 0;
    int          last_retire = 0;
    logic        first_fetch = 1'b0;
    int          checks [NT];
    int          errors [NT];

    `include "rv_ref_model.svh"

    always #20 clk = ~clk;

    core_top core_top_i (
        .clk       (clk),
        .rst       (rst),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    // --------------------------------------------------
    // Program generation
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rnd(input int n);
        logic [31:0] w;
        w = lcg_next();
        return int'({16'h0000, w[31:16]}) % n;  // Upper bits only.
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // Registers stay in x0..x7 so values get reused. Jumps only go forward.
    function automatic logic [31:0] gen_inst(input int i);
        logic [31:0] word;
        logic [31:0] off;
        logic [31:0] inst;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        int          tgt;
        word = lcg_next();
        rd   = 5'(rnd(8));
        rs1  = 5'(rnd(8));
        rs2  = 5'(rnd(8));
        f3   = 3'(rnd(8));
        imm  = 12'(rnd(4096));
        tgt  = i + 1 + rnd((ROM_W - 1 - i) < 8 ? ROM_W - 1 - i : 8);
        off  = 32'((tgt - i) * 4);
        case (rnd(16))
            0, 1, 2, 3, 4: begin
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    imm[11:5] = (f3 == F3_SR && rnd(2) == 1) ? 7'b0100000 : 7'b0;
                end
                inst = {imm, rs1, f3, rd, OP_IMM};
            end
            5, 6, 7, 8: begin
                inst = {((f3 == F3_ADD || f3 == F3_SR) && rnd(2) == 1) ? 7'b0100000 : 7'b0,
                        rs2, rs1, f3, rd, OP_REG};
            end
            9:  inst = {word[31:12], rd, OP_LUI};
            10: inst = {word[31:12], rd, OP_AUIPC};
            11: inst = jal_word(off, rd);
            12: inst = {12'(tgt * 4 + rnd(2)), 5'd0, 3'b000, rd, OP_JALR};  // Bit 0 gets cleared.
            13, 14: begin
                inst = {off[12], off[10:5], rs2, rs1, f3[2], 1'b0, f3[0], off[4:1], off[11],
                        OP_BRANCH};
            end
            default: begin
                if (f3[1]) begin
                    inst = {off[12], off[10:5], rs2, rs1, f3[2], 1'b1, f3[0], off[4:1],
                            off[11], OP_BRANCH};  // Unsupported branch funct3.
                end else begin
                    inst = {word[31:7], (rnd(2) == 1) ? 7'b0000011 : 7'b1110011};
                end
            end
        endcase
        return inst;
    endfunction

    // --------------------------------------------------
    // Checking and reporting
    // --------------------------------------------------
    function automatic string test_name(input int t);
        case (t)
            T_RESET: return "reset";
            T_SEQ:   return "sequence";
            T_ALU:   return "alu";
            T_UPPER: return "upper";
            T_CTRL:  return "control";
            default: return "illegal";
        endcase
    endfunction

    function automatic int test_of(input logic [6:0] opc);
        case (opc)
            OP_IMM, OP_REG:   return T_ALU;
            OP_LUI, OP_AUIPC: return T_UPPER;
            default:          return T_CTRL;
        endcase
    endfunction

    task automatic check_value(input int t, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("Error %s %s: expected %0h, actual %0h", test_name(t), what, exp, act);
        end
    endtask

    task automatic report(input int t, inout int fails);
        int bad;
        bad = errors[t];
        if (checks[t] == 0) begin
            bad++;
            $display("Test %s retired no instruction of its kind", test_name(t));
        end
        $display("Test %s: %0d checks, %0d errors", test_name(t), checks[t], bad);
        fails += bad;
    endtask

    // Read data is valid only in the cycle after the request.
    always @(negedge clk) begin
        req_q     <= imem_req;
        addr_q    <= imem_addr;
        imem_data <= req_q ? rom[addr_q[5:0]] : '0;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("Timeout: %0d of %0d instructions retired in %0d cycles",
                     retire_cnt, N_INSTR, TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    // Compares every retire record against the reference model.
    always @(negedge clk) begin
        retire_t     exp;
        logic [31:0] inst;
        int          t;
        if (cycle_cnt <= RST_CYC) begin
            check_value(T_RESET, "imem_req", 32'd0, 32'(imem_req));
            check_value(T_RESET, "retire.valid", 32'd0, 32'(retire.valid));
        end else if (!first_fetch && imem_req) begin
            check_value(T_RESET, "first imem_addr", 32'd0, 32'(imem_addr));
            first_fetch = 1'b1;
            last_retire = cycle_cnt;  // Fetch to retire is also 4 cycles.
        end
        if (cycle_cnt > RST_CYC && retire.valid) begin
            inst = rom[ref_pc[7:2]];
            exp  = ref_step(inst);
            t    = exp.illegal ? T_ILL : test_of(inst[6:0]);
            check_value(t, "pc", exp.pc, retire.pc);
            check_value(t, "rd", 32'(exp.rd), 32'(retire.rd));
            check_value(t, "illegal", 32'(exp.illegal), 32'(retire.illegal));
            check_value(t, "wr_en", 32'(exp.wr_en), 32'(retire.wr_en));
            check_value(t, "next_pc", exp.next_pc, retire.next_pc);
            if (!exp.illegal && inst[6:0] != OP_BRANCH) begin
                check_value(t, "value", exp.value, retire.value);
            end
            // Next fetch starts in the same cycle.
            check_value(T_SEQ, "imem_req", 32'd1, 32'(imem_req));
            check_value(T_SEQ, "fetch address", exp.next_pc >> 2, {2'b00, imem_addr});
            check_value(T_SEQ, "retire spacing", 32'd4, cycle_cnt - last_retire);
            last_retire = cycle_cnt;
            retire_cnt++;
        end
    end

    initial begin
        int fails;
        int nchk;
        fails = 0;
        nchk  = 0;
        for (int i = 0; i < ROM_W - 1; i++) begin
            rom[i] = gen_inst(i);
        end
        rom[ROM_W-1] = jal_word(32'(-(ROM_W - 1) * 4), 5'd0);  // Back to 0.
        repeat (RST_CYC) @(negedge clk);
        rst = 1'b0;
        wait (first_fetch);
        report(T_RESET, fails);
        wait (retire_cnt >= N_INSTR);
        for (int t = T_SEQ; t < NT; t++) begin
            report(t, fails);
        end
        for (int t = 0; t < NT; t++) begin
            nchk += checks[t];
        end
        $display("Tests: %0d, instructions: %0d, checks: %0d, errors: %0d",
                 NT, retire_cnt, nchk, fails);
        if (fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+sim
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/core_top.sv
sim/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
